// File: verilog/dec_params.svh
// ########################################
// Sizes of the dual-slot decode stage
// ########################################
`ifndef DEC_PARAMS_SVH
`define DEC_PARAMS_SVH

`default_nettype none

// Decode slots per fetch window
`define DEC_NUM 2

`define DEC_BLOCK (2 * `DEC_NUM)          // Full-width and compressed entry per slot

`define DEC_DEPTH 2                       // Fetch blocks kept in history

`define FETCH_W (16 * (`DEC_NUM + 1))     // Three halfwords

`default_nettype wire

`endif

// File: verilog/dec_pkg.sv
// ########################################
// Instruction formats and decoded entry
// ########################################
`default_nettype none

package dec_pkg;

    typedef enum logic [2:0] {
        ISA_R = 3'd0,
        ISA_I = 3'd1,
        ISA_S = 3'd2,
        ISA_B = 3'd3,
        ISA_U = 3'd4,
        ISA_J = 3'd5
    } isa_e;

    typedef enum logic [1:0] {
        MEMOP_1B = 2'd0,
        MEMOP_2B = 2'd1,
        MEMOP_4B = 2'd2
    } memsize_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_s;

    typedef struct packed {
        logic [11:0] imm11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_s;

    typedef struct packed {
        logic [6:0] imm11_5;              // Also B-type imm 12|10:5
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;               // Also B-type imm 4:1|11
        logic [6:0] opcode;
    } s_fmt_s;

    typedef struct packed {
        logic [19:0] imm31_12;            // Also J-type imm pieces
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_s;

    // One 32-bit word seen through every base format
    typedef union packed {
        r_fmt_s r;
        i_fmt_s i;
        s_fmt_s s;
        u_fmt_s u;
    } instr_u;

    typedef struct packed {
        logic [31:0] pc;                  // Kept first, reset value is all ones
        logic [31:0] instr;
        logic        compressed;
        logic [4:0]  radr1;
        logic [4:0]  radr2;
        logic [4:0]  waddr;
        logic [31:0] imm;
        isa_e        isa;
        logic        memop_load;
        logic        memop_store;
        logic        memop_sign_ext;
        memsize_e    memop_size;
        logic        exception;
        logic        load_fault;
    } dec_entry_s;

endpackage

`default_nettype wire

// File: verilog/dec_rv.sv
// ########################################
// RV32 full-width decoder, base subset
// ########################################
`default_nettype none

module dec_rv (
    input  logic              i_instr_load_fault,
    input  logic [31:0]       i_instr,
    output logic              o_compressed,
    output logic [4:0]        o_radr1,
    output logic [4:0]        o_radr2,
    output logic [4:0]        o_waddr,
    output logic [31:0]       o_imm,
    output dec_pkg::isa_e     o_isa,
    output logic              o_memop_load,
    output logic              o_memop_store,
    output logic              o_memop_sign_ext,
    output dec_pkg::memsize_e o_memop_size,
    output logic              o_exception,
    output logic              o_load_fault
);

    dec_pkg::instr_u w;
    logic            unknown;

    assign w            = i_instr;
    assign o_compressed = (i_instr[1:0] != 2'b11);
    assign o_load_fault = i_instr_load_fault;
    assign o_exception  = unknown & ~o_compressed;   // C words belong to dec_rvc

    always_comb begin
        o_radr1          = 5'd0;
        o_radr2          = 5'd0;
        o_waddr          = 5'd0;
        o_imm            = 32'd0;
        o_isa            = dec_pkg::ISA_I;
        o_memop_load     = 1'b0;
        o_memop_store    = 1'b0;
        o_memop_sign_ext = 1'b0;
        o_memop_size     = dec_pkg::MEMOP_1B;
        unknown          = 1'b0;
        case (w.r.opcode)
            7'b0110111, 7'b0010111: begin                // LUI, AUIPC
                o_isa   = dec_pkg::ISA_U;
                o_waddr = w.u.rd;
                o_imm   = {w.u.imm31_12, 12'd0};
            end
            7'b1101111: begin                            // JAL
                o_isa   = dec_pkg::ISA_J;
                o_waddr = w.u.rd;
                o_imm   = {{12{w.u.imm31_12[19]}}, w.u.imm31_12[7:0],
                           w.u.imm31_12[8], w.u.imm31_12[18:9], 1'b0};
            end
            7'b1100111: begin                            // JALR
                o_radr1 = w.i.rs1;
                o_waddr = w.i.rd;
                o_imm   = {{20{w.i.imm11_0[11]}}, w.i.imm11_0};
                unknown = (w.i.funct3 != 3'b000);
            end
            7'b1100011: begin                            // Branches
                o_isa   = dec_pkg::ISA_B;
                o_radr1 = w.s.rs1;
                o_radr2 = w.s.rs2;
                o_imm   = {{20{w.s.imm11_5[6]}}, w.s.imm4_0[0], w.s.imm11_5[5:0],
                           w.s.imm4_0[4:1], 1'b0};
                unknown = (w.s.funct3[2:1] == 2'b01);
            end
            7'b0000011: begin                            // Loads
                o_radr1          = w.i.rs1;
                o_waddr          = w.i.rd;
                o_imm            = {{20{w.i.imm11_0[11]}}, w.i.imm11_0};
                o_memop_load     = 1'b1;
                o_memop_sign_ext = ~w.i.funct3[2];
                o_memop_size     = dec_pkg::memsize_e'(w.i.funct3[1:0]);
                unknown          = (w.i.funct3[1:0] == 2'b11) || (w.i.funct3 == 3'b110);
            end
            7'b0100011: begin                            // Stores
                o_isa         = dec_pkg::ISA_S;
                o_radr1       = w.s.rs1;
                o_radr2       = w.s.rs2;
                o_imm         = {{20{w.s.imm11_5[6]}}, w.s.imm11_5, w.s.imm4_0};
                o_memop_store = 1'b1;
                o_memop_size  = dec_pkg::memsize_e'(w.s.funct3[1:0]);
                unknown       = w.s.funct3[2] || (w.s.funct3[1:0] == 2'b11);
            end
            7'b0010011: begin                            // OP-IMM
                o_radr1 = w.i.rs1;
                o_waddr = w.i.rd;
                o_imm   = {{20{w.i.imm11_0[11]}}, w.i.imm11_0};
                if (w.r.funct3 == 3'b001) begin
                    unknown = (w.r.funct7 != 7'd0);
                end else if (w.r.funct3 == 3'b101) begin
                    unknown = (w.r.funct7 != 7'd0) && (w.r.funct7 != 7'b0100000);
                end
            end
            7'b0110011: begin                            // OP
                o_isa   = dec_pkg::ISA_R;
                o_radr1 = w.r.rs1;
                o_radr2 = w.r.rs2;
                o_waddr = w.r.rd;
                if (w.r.funct7 == 7'b0100000) begin
                    unknown = (w.r.funct3 != 3'b000) && (w.r.funct3 != 3'b101);  // SUB, SRA
                end else begin
                    unknown = (w.r.funct7 != 7'd0);
                end
            end
            default: begin
                unknown = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/dec_rvc.sv
// ########################################
// RV32C compressed decoder, small subset
// ########################################
`default_nettype none

module dec_rvc (
    input  logic              i_instr_load_fault,
    input  logic [15:0]       i_instr,
    output logic [4:0]        o_radr1,
    output logic [4:0]        o_radr2,
    output logic [4:0]        o_waddr,
    output logic [31:0]       o_imm,
    output dec_pkg::isa_e     o_isa,
    output logic              o_memop_load,
    output logic              o_memop_store,
    output logic              o_memop_sign_ext,
    output dec_pkg::memsize_e o_memop_size,
    output logic              o_exception,
    output logic              o_load_fault
);

    logic [4:0]  rs1_p;
    logic [4:0]  rd_p;
    logic [31:0] imm_ci;
    logic [31:0] imm_lw;
    logic [31:0] imm_cj;

    assign rs1_p  = {2'b01, i_instr[9:7]};      // x8..x15
    assign rd_p   = {2'b01, i_instr[4:2]};
    assign imm_ci = {{27{i_instr[12]}}, i_instr[6:2]};
    assign imm_lw = {25'd0, i_instr[5], i_instr[12:10], i_instr[6], 2'b00};
    assign imm_cj = {{21{i_instr[12]}}, i_instr[8], i_instr[10:9], i_instr[6],
                     i_instr[7], i_instr[2], i_instr[11], i_instr[5:3], 1'b0};

    assign o_load_fault = i_instr_load_fault;

    always_comb begin
        o_radr1          = 5'd0;
        o_radr2          = 5'd0;
        o_waddr          = 5'd0;
        o_imm            = 32'd0;
        o_isa            = dec_pkg::ISA_I;
        o_memop_load     = 1'b0;
        o_memop_store    = 1'b0;
        o_memop_sign_ext = 1'b0;
        o_memop_size     = dec_pkg::MEMOP_1B;
        o_exception      = 1'b0;
        case ({i_instr[15:13], i_instr[1:0]})
            5'b010_00: begin                            // C.LW
                o_radr1          = rs1_p;
                o_waddr          = rd_p;
                o_imm            = imm_lw;
                o_memop_load     = 1'b1;
                o_memop_sign_ext = 1'b1;
                o_memop_size     = dec_pkg::MEMOP_4B;
            end
            5'b110_00: begin                            // C.SW
                o_isa         = dec_pkg::ISA_S;
                o_radr1       = rs1_p;
                o_radr2       = rd_p;
                o_imm         = imm_lw;
                o_memop_store = 1'b1;
                o_memop_size  = dec_pkg::MEMOP_4B;
            end
            5'b000_01: begin                            // C.ADDI
                o_radr1 = i_instr[11:7];
                o_waddr = i_instr[11:7];
                o_imm   = imm_ci;
            end
            5'b010_01: begin                            // C.LI, addi rd,x0,imm
                o_waddr = i_instr[11:7];
                o_imm   = imm_ci;
            end
            5'b101_01: begin                            // C.J, jal x0
                o_isa = dec_pkg::ISA_J;
                o_imm = imm_cj;
            end
            5'b100_10: begin                            // C.MV or C.ADD
                o_isa       = dec_pkg::ISA_R;
                o_radr1     = i_instr[12] ? i_instr[11:7] : 5'd0;
                o_radr2     = i_instr[6:2];
                o_waddr     = i_instr[11:7];
                o_exception = (i_instr[6:2] == 5'd0);  // JR, JALR, EBREAK not supported
            end
            default: begin
                o_exception = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/dec_history.sv
// ########################################
// Decoded block history, pc lookup
// ########################################
`include "dec_params.svh"
`default_nettype none

module dec_history (
    input  logic               i_clk,
    input  logic               i_nrst,
    input  logic               i_flush_pipeline,
    input  dec_pkg::dec_entry_s i_new [`DEC_BLOCK],
    input  logic [31:0]        i_f_pc,
    input  logic [31:0]        i_e_npc,
    output logic               o_valid,
    output logic [31:0]        o_pc,
    output logic [31:0]        o_instr,
    output logic               o_compressed,
    output logic [4:0]         o_radr1,
    output logic [4:0]         o_radr2,
    output logic [4:0]         o_waddr,
    output logic [31:0]        o_imm,
    output dec_pkg::isa_e      o_isa_type,
    output logic               o_memop_load,
    output logic               o_memop_store,
    output logic               o_memop_sign_ext,
    output dec_pkg::memsize_e  o_memop_size,
    output logic               o_exception,
    output logic               o_instr_load_fault
);

    // Odd pc never requested, flags all clear
    localparam dec_pkg::dec_entry_s CLEARED = dec_pkg::dec_entry_s'(
        {32'hFFFF_FFFF, {($bits(dec_pkg::dec_entry_s) - 32){1'b0}}});

    dec_pkg::dec_entry_s hist [`DEC_DEPTH][`DEC_BLOCK];  // Block 0 is newest
    dec_pkg::dec_entry_s blk [`DEC_DEPTH + 1][`DEC_BLOCK];
    dec_pkg::dec_entry_s sel;
    logic                shift_ena;

    assign shift_ena = (i_f_pc != hist[0][0].pc);

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            for (int b = 0; b < `DEC_DEPTH; b++) begin
                for (int e = 0; e < `DEC_BLOCK; e++) begin
                    hist[b][e] <= CLEARED;
                end
            end
        end else if (i_flush_pipeline) begin
            for (int b = 0; b < `DEC_DEPTH; b++) begin
                for (int e = 0; e < `DEC_BLOCK; e++) begin
                    hist[b][e] <= CLEARED;
                end
            end
        end else if (shift_ena) begin
            hist[0] <= i_new;                          // Live block enters history
            for (int b = 1; b < `DEC_DEPTH; b++) begin
                hist[b] <= hist[b - 1];
            end
        end
    end

    // Oldest searched first so that a newer match overrides it
    always_comb begin
        blk[0] = i_new;
        for (int b = 0; b < `DEC_DEPTH; b++) begin
            blk[b + 1] = hist[b];
        end
        sel     = CLEARED;
        o_valid = 1'b0;
        for (int b = `DEC_DEPTH; b >= 0; b--) begin
            for (int s = 0; s < `DEC_NUM; s++) begin
                if (blk[b][2 * s].pc == i_e_npc) begin
                    o_valid = 1'b1;
                    sel     = blk[b][2 * s].compressed ? blk[b][2 * s + 1] : blk[b][2 * s];
                end
            end
        end
    end

    assign o_pc               = sel.pc;
    assign o_instr            = sel.instr;
    assign o_compressed       = sel.compressed;
    assign o_radr1            = sel.radr1;
    assign o_radr2            = sel.radr2;
    assign o_waddr            = sel.waddr;
    assign o_imm              = sel.imm;
    assign o_isa_type         = sel.isa;
    assign o_memop_load       = sel.memop_load;
    assign o_memop_store      = sel.memop_store;
    assign o_memop_sign_ext   = sel.memop_sign_ext;
    assign o_memop_size       = sel.memop_size;
    assign o_exception        = sel.exception;
    assign o_instr_load_fault = sel.load_fault;

endmodule

`default_nettype wire

// File: verilog/instr_decoder.sv
// ########################################
// Dual-slot decode stage, top level
// ########################################
`include "dec_params.svh"
`default_nettype none

module instr_decoder (
    input  logic                i_clk,
    input  logic                i_nrst,
    input  logic [31:0]         i_f_pc,
    input  logic [`FETCH_W-1:0] i_f_instr,
    input  logic                i_instr_load_fault,
    input  logic [31:0]         i_e_npc,
    input  logic                i_flush_pipeline,
    output logic                o_valid,
    output logic [31:0]         o_pc,
    output logic [31:0]         o_instr,
    output logic                o_compressed,
    output logic [4:0]          o_radr1,
    output logic [4:0]          o_radr2,
    output logic [4:0]          o_waddr,
    output logic [31:0]         o_imm,
    output dec_pkg::isa_e       o_isa_type,
    output logic                o_memop_load,
    output logic                o_memop_store,
    output logic                o_memop_sign_ext,
    output dec_pkg::memsize_e   o_memop_size,
    output logic                o_exception,
    output logic                o_instr_load_fault
);

    wire dec_pkg::dec_entry_s wd [`DEC_BLOCK];   // Entry 2s full-width, 2s+1 compressed

    for (genvar s = 0; s < `DEC_NUM; s++) begin : g_slot
        logic [31:0] slot_pc;
        logic [31:0] slot_instr;

        assign slot_pc    = i_f_pc + 32'(2 * s);
        assign slot_instr = i_f_instr[16 * s +: 32];

        assign wd[2 * s].pc         = slot_pc;
        assign wd[2 * s].instr      = slot_instr;
        assign wd[2 * s + 1].pc     = slot_pc;
        assign wd[2 * s + 1].instr  = slot_instr;
        assign wd[2 * s + 1].compressed = 1'b1;

        dec_rv u_rv (
            .i_instr_load_fault(i_instr_load_fault),
            .i_instr(slot_instr),
            .o_compressed(wd[2 * s].compressed),
            .o_radr1(wd[2 * s].radr1),
            .o_radr2(wd[2 * s].radr2),
            .o_waddr(wd[2 * s].waddr),
            .o_imm(wd[2 * s].imm),
            .o_isa(wd[2 * s].isa),
            .o_memop_load(wd[2 * s].memop_load),
            .o_memop_store(wd[2 * s].memop_store),
            .o_memop_sign_ext(wd[2 * s].memop_sign_ext),
            .o_memop_size(wd[2 * s].memop_size),
            .o_exception(wd[2 * s].exception),
            .o_load_fault(wd[2 * s].load_fault)
        );

        dec_rvc u_rvc (
            .i_instr_load_fault(i_instr_load_fault),
            .i_instr(slot_instr[15:0]),
            .o_radr1(wd[2 * s + 1].radr1),
            .o_radr2(wd[2 * s + 1].radr2),
            .o_waddr(wd[2 * s + 1].waddr),
            .o_imm(wd[2 * s + 1].imm),
            .o_isa(wd[2 * s + 1].isa),
            .o_memop_load(wd[2 * s + 1].memop_load),
            .o_memop_store(wd[2 * s + 1].memop_store),
            .o_memop_sign_ext(wd[2 * s + 1].memop_sign_ext),
            .o_memop_size(wd[2 * s + 1].memop_size),
            .o_exception(wd[2 * s + 1].exception),
            .o_load_fault(wd[2 * s + 1].load_fault)
        );
    end

    dec_history u_history (
        .i_clk(i_clk),
        .i_nrst(i_nrst),
        .i_flush_pipeline(i_flush_pipeline),
        .i_new(wd),
        .i_f_pc(i_f_pc),
        .i_e_npc(i_e_npc),
        .o_valid(o_valid),
        .o_pc(o_pc),
        .o_instr(o_instr),
        .o_compressed(o_compressed),
        .o_radr1(o_radr1),
        .o_radr2(o_radr2),
        .o_waddr(o_waddr),
        .o_imm(o_imm),
        .o_isa_type(o_isa_type),
        .o_memop_load(o_memop_load),
        .o_memop_store(o_memop_store),
        .o_memop_sign_ext(o_memop_sign_ext),
        .o_memop_size(o_memop_size),
        .o_exception(o_exception),
        .o_instr_load_fault(o_instr_load_fault)
    );

endmodule

`default_nettype wire

// File: bench/instr_decoder_asserts.sv
// ########################################
// Assertions on the decoded block history
// ########################################
`include "dec_params.svh"
`default_nettype none

module instr_decoder_asserts (
    input logic                i_clk,
    input logic                i_nrst,
    input logic                i_flush_pipeline,
    input logic [31:0]         i_e_npc,
    input logic                o_valid,
    input logic [31:0]         o_pc,
    input logic                o_memop_load,
    input logic                o_memop_store,
    input dec_pkg::dec_entry_s hist [`DEC_DEPTH][`DEC_BLOCK]
);
    timeunit 1ns;
    timeprecision 100ps;

    logic hist_hit;

    always_comb begin
        hist_hit = 1'b0;
        for (int b = 0; b < `DEC_DEPTH; b++) begin
            for (int s = 0; s < `DEC_NUM; s++) begin
                if (hist[b][2 * s].pc == i_e_npc) begin
                    hist_hit = 1'b1;
                end
            end
        end
    end

    a_valid_pc: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_valid |-> (o_pc == i_e_npc)) else $error("o_pc differs from requested pc");

    a_flush_clear: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_flush_pipeline |=> !hist_hit) else $error("history hit right after flush");

    a_ld_st: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !(o_memop_load && o_memop_store)) else $error("load and store both high");

endmodule

bind dec_history instr_decoder_asserts u_asserts (
    .i_clk(i_clk),
    .i_nrst(i_nrst),
    .i_flush_pipeline(i_flush_pipeline),
    .i_e_npc(i_e_npc),
    .o_valid(o_valid),
    .o_pc(o_pc),
    .o_memop_load(o_memop_load),
    .o_memop_store(o_memop_store),
    .hist(hist)
);

`default_nettype wire

// File: bench/instr_decoder_tb.sv
// ########################################
// Table-driven testbench of the decode stage
// ########################################
`include "dec_params.svh"
`default_nettype none

module instr_decoder_tb;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct {
        logic [31:0]         pc;
        logic [47:0]         win;
        logic                lf;
        logic [31:0]         npc;
        logic                fl;
        logic                v;
        logic                cmp;
        logic [4:0]          r1;
        logic [4:0]          r2;
        logic [4:0]          wa;
        logic [31:0]         imm;
        dec_pkg::isa_e       isa;
        logic                ld;
        logic                st;
        dec_pkg::memsize_e   sz;
        logic                exc;
        logic                lfo;
        logic                se;
        logic [31:0]         ins;
    } row_s;

    logic                i_clk;
    logic                i_nrst;
    logic [31:0]         i_f_pc;
    logic [`FETCH_W-1:0] i_f_instr;
    logic                i_instr_load_fault;
    logic [31:0]         i_e_npc;
    logic                i_flush_pipeline;
    logic                o_valid;
    logic [31:0]         o_pc;
    logic [31:0]         o_instr;
    logic                o_compressed;
    logic [4:0]          o_radr1;
    logic [4:0]          o_radr2;
    logic [4:0]          o_waddr;
    logic [31:0]         o_imm;
    dec_pkg::isa_e       o_isa_type;
    logic                o_memop_load;
    logic                o_memop_store;
    logic                o_memop_sign_ext;
    dec_pkg::memsize_e   o_memop_size;
    logic                o_exception;
    logic                o_instr_load_fault;

    row_s rows [$];
    int   cycles = 0;
    int   limit = 0;
    int   failed_rows = 0;

    instr_decoder i_instr_decoder (.*);

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;                  // 8 ns period
    end

    always @(posedge i_clk) begin
        cycles++;
        if (limit != 0 && cycles >= limit) begin
            $display("Run stopped: cycle limit of %0d reached", limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic add_row(input logic [31:0] pc, input logic [47:0] win, input logic lf,
                           input logic [31:0] npc, input logic fl, input logic v,
                           input logic cmp, input logic [4:0] r1, input logic [4:0] r2,
                           input logic [4:0] wa, input logic [31:0] imm,
                           input dec_pkg::isa_e isa, input logic ld, input logic st,
                           input dec_pkg::memsize_e sz, input logic exc, input logic lfo,
                           input logic se, input logic [31:0] ins);
        row_s r;
        r = '{pc, win, lf, npc, fl, v, cmp, r1, r2, wa, imm, isa, ld, st, sz, exc, lfo, se,
              ins};
        rows.push_back(r);
    endtask

    task automatic check_val(input int n, input string name, input logic [31:0] got,
                             input logic [31:0] exp, inout int bad);
        if (got !== exp) begin
            $display("Error at %0t ns: row %0d %s is %h, expected %h", $time, n, name, got, exp);
            bad++;
        end
    endtask

    initial begin
        int bad;
        i_nrst             = 1'b0;
        i_f_pc             = 32'd0;
        i_f_instr          = '0;
        i_instr_load_fault = 1'b0;
        i_e_npc            = 32'd0;
        i_flush_pipeline   = 1'b0;

        // Full-width LUI, ADDI, LW, SW, BEQ, JAL and ADD
        add_row(32'h100, 48'h0000_1234_52B7, 0, 32'h100, 0, 1, 0, 0, 0, 5, 32'h1234_5000,
                dec_pkg::ISA_U, 0, 0, dec_pkg::MEMOP_1B, 0, 0, 0, 32'h1234_52B7);
        add_row(32'h110, 48'h0000_FFF1_0093, 0, 32'h110, 0, 1, 0, 2, 0, 1, 32'hFFFF_FFFF,
                dec_pkg::ISA_I, 0, 0, dec_pkg::MEMOP_1B, 0, 0, 0, 32'hFFF1_0093);
        add_row(32'h120, 48'h0000_0082_2183, 0, 32'h120, 0, 1, 0, 4, 0, 3, 32'd8,
                dec_pkg::ISA_I, 1, 0, dec_pkg::MEMOP_4B, 0, 0, 1, 32'h0082_2183);
        add_row(32'h130, 48'h0000_0053_2623, 0, 32'h130, 0, 1, 0, 6, 5, 0, 32'd12,
                dec_pkg::ISA_S, 0, 1, dec_pkg::MEMOP_4B, 0, 0, 0, 32'h0053_2623);
        add_row(32'h140, 48'h0000_0020_8863, 0, 32'h140, 0, 1, 0, 1, 2, 0, 32'd16,
                dec_pkg::ISA_B, 0, 0, dec_pkg::MEMOP_1B, 0, 0, 0, 32'h0020_8863);
        add_row(32'h150, 48'h0000_0080_00EF, 0, 32'h150, 0, 1, 0, 0, 0, 1, 32'd8,
                dec_pkg::ISA_J, 0, 0, dec_pkg::MEMOP_1B, 0, 0, 0, 32'h0080_00EF);
        add_row(32'h160, 48'h0000_0020_81B3, 0, 32'h160, 0, 1, 0, 1, 2, 3, 32'd0,
                dec_pkg::ISA_R, 0, 0, dec_pkg::MEMOP_1B, 0, 0, 0, 32'h0020_81B3);
        // Each C form in slot 0, then C.ADDI in slot 1
        add_row(32'h200, 48'h0000_0000_1475, 0, 32'h200, 0, 1, 1, 8, 0, 8, 32'hFFFF_FFFD,
                dec_pkg::ISA_I, 0, 0, dec_pkg::MEMOP_1B, 0, 0, 0, 32'h0000_1475);
        add_row(32'h210, 48'h0000_0000_4515, 0, 32'h210, 0, 1, 1, 0, 0, 10, 32'd5,
                dec_pkg::ISA_I, 0, 0, dec_pkg::MEMOP_1B, 0, 0, 0, 32'h0000_4515);
        add_row(32'h220, 48'h0000_0000_4144, 0, 32'h220, 0, 1, 1, 10, 0, 9, 32'd4,
                dec_pkg::ISA_I, 1, 0, dec_pkg::MEMOP_4B, 0, 0, 1, 32'h0000_4144);
        add_row(32'h230, 48'h0000_0000_C60C, 0, 32'h230, 0, 1, 1, 12, 11, 0, 32'd8,
                dec_pkg::ISA_S, 0, 1, dec_pkg::MEMOP_4B, 0, 0, 0, 32'h0000_C60C);
        add_row(32'h240, 48'h0000_0000_A011, 0, 32'h240, 0, 1, 1, 0, 0, 0, 32'd4,
                dec_pkg::ISA_J, 0, 0, dec_pkg::MEMOP_1B, 0, 0, 0, 32'h0000_A011);
        add_row(32'h250, 48'h0000_0000_829A, 0, 32'h250, 0, 1, 1, 0, 6, 5, 32'd0,
                dec_pkg::ISA_R, 0, 0, dec_pkg::MEMOP_1B, 0, 0, 0, 32'h0000_829A);
        add_row(32'h260, 48'h0000_0000_929A, 0, 32'h260, 0, 1, 1, 5, 6, 5, 32'd0,
                dec_pkg::ISA_R, 0, 0, dec_pkg::MEMOP_1B, 0, 0, 0, 32'h0000_929A);
        add_row(32'h300, 48'h0000_1475_0001, 0, 32'h302, 0, 1, 1, 8, 0, 8, 32'hFFFF_FFFD,
                dec_pkg::ISA_I, 0, 0, dec_pkg::MEMOP_1B, 0, 0, 0, 32'h0000_1475);
        // Mixed window with C.LI then ADD at pc plus 2
        add_row(32'h400, 48'h0020_81B3_4515, 0, 32'h402, 0, 1, 0, 1, 2, 3, 32'd0,
                dec_pkg::ISA_R, 0, 0, dec_pkg::MEMOP_1B, 0, 0, 0, 32'h0020_81B3);
        // History 0, history 1, then dropped out
        add_row(32'h500, 48'h0, 0, 32'h402, 0, 1, 0, 1, 2, 3, 32'd0,
                dec_pkg::ISA_R, 0, 0, dec_pkg::MEMOP_1B, 0, 0, 0, 32'h0020_81B3);
        add_row(32'h600, 48'h0, 0, 32'h402, 0, 1, 0, 1, 2, 3, 32'd0,
                dec_pkg::ISA_R, 0, 0, dec_pkg::MEMOP_1B, 0, 0, 0, 32'h0020_81B3);
        add_row(32'h700, 48'h0, 0, 32'h402, 0, 0, 0, 0, 0, 0, 32'd0,
                dec_pkg::ISA_R, 0, 0, dec_pkg::MEMOP_1B, 0, 0, 0, 32'd0);
        // Flush pulse so the old pc 0x602 is gone
        add_row(32'h700, 48'h0, 0, 32'h7FF0, 1, 0, 0, 0, 0, 0, 32'd0,
                dec_pkg::ISA_R, 0, 0, dec_pkg::MEMOP_1B, 0, 0, 0, 32'd0);
        add_row(32'h700, 48'h0, 0, 32'h602, 0, 0, 0, 0, 0, 0, 32'd0,
                dec_pkg::ISA_R, 0, 0, dec_pkg::MEMOP_1B, 0, 0, 0, 32'd0);
        // Unknown opcode, unknown C code, load fault
        add_row(32'h800, 48'h0000_0000_007F, 0, 32'h800, 0, 1, 0, 0, 0, 0, 32'd0,
                dec_pkg::ISA_I, 0, 0, dec_pkg::MEMOP_1B, 1, 0, 0, 32'h0000_007F);
        add_row(32'h900, 48'h0, 0, 32'h900, 0, 1, 1, 0, 0, 0, 32'd0,
                dec_pkg::ISA_I, 0, 0, dec_pkg::MEMOP_1B, 1, 0, 0, 32'd0);
        add_row(32'hA00, 48'h0000_1234_52B7, 1, 32'hA00, 0, 1, 0, 0, 0, 5, 32'h1234_5000,
                dec_pkg::ISA_U, 0, 0, dec_pkg::MEMOP_1B, 0, 1, 0, 32'h1234_52B7);

        limit = rows.size() * 4 + 50;
        repeat (8) @(posedge i_clk);
        #1 i_nrst = 1'b1;

        for (int n = 0; n < rows.size(); n++) begin
            @(posedge i_clk);
            #1;                                      // Drive just after the edge
            i_f_pc             = rows[n].pc;
            i_f_instr          = rows[n].win;
            i_instr_load_fault = rows[n].lf;
            i_e_npc            = rows[n].npc;
            i_flush_pipeline   = rows[n].fl;
            #6;                                      // Sample just before the next edge
            bad = 0;
            check_val(n, "o_valid", 32'(o_valid), 32'(rows[n].v), bad);
            check_val(n, "o_memop_load", 32'(o_memop_load), 32'(rows[n].ld), bad);
            check_val(n, "o_memop_store", 32'(o_memop_store), 32'(rows[n].st), bad);
            check_val(n, "o_exception", 32'(o_exception), 32'(rows[n].exc), bad);
            if (rows[n].v) begin
                check_val(n, "o_pc", o_pc, rows[n].npc, bad);
                check_val(n, "o_instr", o_instr, rows[n].ins, bad);
                check_val(n, "o_compressed", 32'(o_compressed), 32'(rows[n].cmp), bad);
                check_val(n, "o_radr1", 32'(o_radr1), 32'(rows[n].r1), bad);
                check_val(n, "o_radr2", 32'(o_radr2), 32'(rows[n].r2), bad);
                check_val(n, "o_waddr", 32'(o_waddr), 32'(rows[n].wa), bad);
                check_val(n, "o_imm", o_imm, rows[n].imm, bad);
                check_val(n, "o_isa_type", 32'(o_isa_type), 32'(rows[n].isa), bad);
                check_val(n, "o_memop_size", 32'(o_memop_size), 32'(rows[n].sz), bad);
                check_val(n, "o_memop_sign_ext", 32'(o_memop_sign_ext), 32'(rows[n].se), bad);
                check_val(n, "o_instr_load_fault", 32'(o_instr_load_fault),
                          32'(rows[n].lfo), bad);
            end
            if (bad != 0) begin
                failed_rows++;
            end
            $display("Row %0d pc %h npc %h: %s", n, rows[n].pc, rows[n].npc,
                     (bad == 0) ? "ok" : "mismatch");
        end

        $display("%0d rows run, %0d failed", rows.size(), failed_rows);
        if (failed_rows == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+verilog
verilog/dec_pkg.sv
verilog/dec_rv.sv
verilog/dec_rvc.sv
verilog/dec_history.sv
verilog/instr_decoder.sv
bench/instr_decoder_asserts.sv
bench/instr_decoder_tb.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= project.f
TOP       ?= instr_decoder_tb
RTL_TOP   ?= instr_decoder
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
